// ==== tsc_cpu.f ====
+incdir+common
common/tsc_pkg.sv
control/control.sv
datapath/alu.sv
datapath/register_file.sv
datapath/pc_unit.sv
hdl/cpu.sv
dv/cpu_checker.sv
dv/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: tsc_cpu

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/tsc_pkg.sv
      - control/control.sv
      - datapath/alu.sv
      - datapath/register_file.sv
      - datapath/pc_unit.sv
      - hdl/cpu.sv
  - target: test
    include_dirs:
      - common
    files:
      - dv/cpu_checker.sv
      - dv/cpu_tb.sv

// ==== dv/cpu_tb.sv ====
`timescale 1ns/100ps
`include "tsc_params.svh"

module cpu_tb;
    import tsc_pkg::*;

    logic                  clk;
    logic                  arst_n;
    logic                  done;
    logic [`WORD_SIZE-1:0] i_address;
    logic [`WORD_SIZE-1:0] i_data;
    logic [`WORD_SIZE-1:0] d_address;
    logic [`WORD_SIZE-1:0] d_wdata;
    logic [`WORD_SIZE-1:0] d_rdata;
    logic                  d_read;
    logic                  d_write;
    logic [`WORD_SIZE-1:0] output_port;
    logic                  wwd_valid;
    logic                  is_halted;
    logic [`WORD_SIZE-1:0] num_inst;
    int                    fail_count;
    integer                seed;
    int                    prog_len;
    int                    limit = 0;

    logic [`WORD_SIZE-1:0] rom [0:127];
    logic [`WORD_SIZE-1:0] ram [0:65535];
    logic                  wr_pend;
    logic [`WORD_SIZE-1:0] wr_addr;
    logic [`WORD_SIZE-1:0] wr_data;

    cpu u_cpu (
        .clk         (clk),
        .arst_n      (arst_n),
        .i_address   (i_address),
        .i_data      (i_data),
        .d_address   (d_address),
        .d_wdata     (d_wdata),
        .d_rdata     (d_rdata),
        .d_read      (d_read),
        .d_write     (d_write),
        .output_port (output_port),
        .wwd_valid   (wwd_valid),
        .is_halted   (is_halted),
        .num_inst    (num_inst)
    );

    cpu_checker u_checker (
        .clk         (clk),
        .arst_n      (arst_n),
        .i_address   (i_address),
        .d_address   (d_address),
        .d_wdata     (d_wdata),
        .d_write     (d_write),
        .d_read      (d_read),
        .output_port (output_port),
        .wwd_valid   (wwd_valid),
        .is_halted   (is_halted),
        .num_inst    (num_inst),
        .done        (done),
        .fail_count  (fail_count)
    );

    always #10 clk = ~clk;

    // ########################################
    // Memories
    // ########################################
    assign i_data  = rom[i_address[6:0]];
    assign d_rdata = ram[d_address];

    always @(negedge clk) begin
        wr_pend = d_write;
        wr_addr = d_address;
        wr_data = d_wdata;
    end

    always @(posedge clk) begin
        if (wr_pend === 1'b1) begin
            #2 ram[wr_addr] = wr_data;
        end
    end

    // ########################################
    // Program generation
    // ########################################
    function automatic logic [`WORD_SIZE-1:0] wwd_of(input logic [1:0] r);
        return {OP_RTYPE, r, 4'b0000, FN_WWD};
    endfunction

    task automatic put(input logic [`WORD_SIZE-1:0] instr);
        rom[prog_len] = instr;
        prog_len++;
    endtask

    // One ALU, immediate, load or store instruction
    task automatic put_simple(output logic [1:0] dest);
        logic [31:0] w;
        logic [3:0]  op;
        w = $random(seed);
        if (w[31:29] < 3'd3) begin
            put({OP_RTYPE, w[11:6], 3'b000, w[14:12]});
            dest = w[7:6];
        end else begin
            // 3..7 map onto ADI, ORI, LHI, LWD, SWD
            op = {1'b0, w[31:29]} + 4'd1;
            put({op, w[11:0]});
            dest = w[9:8];
        end
    endtask

    task automatic build_program();
        logic [31:0] w;
        logic [1:0]  d;
        logic [1:0]  rx;
        // Store at the reset PC, held off until reset ends
        w = $random(seed);
        put({OP_SWD, w[11:0]});
        while (prog_len < 100) begin
            w  = $random(seed);
            rx = w[4:3];
            case (w[2:0])
                3'd3: begin
                    // Taken branch skips its 0..3 fillers
                    put({2'b00, w[6:5], w[11:8], 6'b000000, w[13:12]});
                    repeat (w[13:12]) put_simple(d);
                end
                3'd4: begin
                    put({OP_JMP, 12'(prog_len + 2)});
                    put_simple(d);
                end
                3'd5: begin
                    put({OP_JAL, 12'(prog_len + 2)});
                    put_simple(d);
                    put(wwd_of(2'd2));
                end
                3'd6, 3'd7: begin
                    // Target lands just past the filler
                    put({OP_LHI, 2'b00, rx, 8'h00});
                    put({OP_ORI, rx, rx, 8'(prog_len + 3)});
                    put({OP_RTYPE, rx, 4'b0000, w[0] ? FN_JRL : FN_JPR});
                    put_simple(d);
                    if (w[0]) begin
                        put(wwd_of(2'd2));
                    end
                end
                default: begin
                    put_simple(d);
                    put(wwd_of(d));
                end
            endcase
        end
        put({OP_RTYPE, 6'b000000, FN_HLT});
    endtask

    initial begin
        clk      = 1'b0;
        arst_n   = 1'b0;
        done     = 1'b0;
        seed     = 1841;
        prog_len = 0;
        for (int i = 0; i < 128; i++) begin
            rom[i] = {OP_RTYPE, 6'b000000, FN_HLT};
        end
        build_program();
        for (int i = 0; i < 128; i++) begin
            u_checker.imem[i] = rom[i];
        end
        for (int a = 0; a < 65536; a++) begin
            ram[a] = $random(seed);
            u_checker.dmem[a] = ram[a];
        end
        limit = prog_len * 2 + 16 + 100;

        repeat (16) @(posedge clk);
        #2 arst_n = 1'b1;
        wait (is_halted === 1'b1);
        // Let the checker watch the halted core
        repeat (4) @(posedge clk);
        #2 done = 1'b1;
        #1;
        if (fail_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (limit > 0);
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the core never halted", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== dv/cpu_checker.sv ====
`timescale 1ns/100ps
`include "tsc_params.svh"

module cpu_checker (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [`WORD_SIZE-1:0] i_address,
    input  logic [`WORD_SIZE-1:0] d_address,
    input  logic [`WORD_SIZE-1:0] d_wdata,
    input  logic                  d_write,
    input  logic                  d_read,
    input  logic [`WORD_SIZE-1:0] output_port,
    input  logic                  wwd_valid,
    input  logic                  is_halted,
    input  logic [`WORD_SIZE-1:0] num_inst,
    input  logic                  done,
    output int                    fail_count
);
    import tsc_pkg::*;

    localparam int T_FETCH = 0;
    localparam int T_ALU   = 1;
    localparam int T_MEM   = 2;
    localparam int T_LINK  = 3;
    localparam int T_HALT  = 4;
    localparam int T_RESET = 5;

    logic [`WORD_SIZE-1:0] imem [0:127];
    logic [`WORD_SIZE-1:0] dmem [0:65535];
    logic [`WORD_SIZE-1:0] regs [`NUM_REGS];
    logic [`WORD_SIZE-1:0] m_pc;
    logic [`WORD_SIZE-1:0] m_count;
    logic                  link_fresh;
    logic                  first_cycle;
    int                    checks [6];
    int                    fails [6];

    function automatic string test_label(input int t);
        case (t)
            T_FETCH: return "fetch sequence";
            T_ALU:   return "alu and immediate results";
            T_MEM:   return "memory traffic";
            T_LINK:  return "link registers";
            T_HALT:  return "halt and count";
            default: return "reset state";
        endcase
    endfunction

    task automatic compare(input int t, input string sig,
                           input logic [`WORD_SIZE-1:0] exp,
                           input logic [`WORD_SIZE-1:0] act);
        checks[t]++;
        if (act !== exp) begin
            fails[t]++;
            fail_count++;
            $display("FAILED %s at %0t: expected %h, actual %h", sig, $time, exp, act);
        end
    endtask

    task automatic set_reg(input logic [1:0] idx, input logic [`WORD_SIZE-1:0] v);
        regs[idx] = v;
        if (idx == 2'd2) begin
            link_fresh = 1'b0;
        end
    endtask

    // Strobes are only forced low while reset is held
    task automatic check_reset(input logic in_reset);
        compare(T_RESET, "i_address", `WORD_SIZE'(`PC_RESET), i_address);
        compare(T_RESET, "num_inst", '0, num_inst);
        if (in_reset) begin
            compare(T_RESET, "d_write", '0, d_write);
            compare(T_RESET, "wwd_valid", '0, wwd_valid);
        end
    endtask

    // ########################################
    // ISA model, one instruction per call
    // ########################################
    task automatic check_and_step();
        logic [`WORD_SIZE-1:0] instr;
        logic [`WORD_SIZE-1:0] imm;
        logic [`WORD_SIZE-1:0] next_pc;
        logic [`WORD_SIZE-1:0] jreg;
        logic [1:0]            rs;
        logic [1:0]            rt;
        logic [1:0]            rd;
        opcode_t               op;
        funct_t                fn;
        logic                  hlt;
        logic                  wwd;
        instr = imem[m_pc[6:0]];
        op    = opcode_t'(instr[15:12]);
        fn    = funct_t'(instr[5:0]);
        rs    = instr[11:10];
        rt    = instr[9:8];
        rd    = instr[7:6];
        imm   = {{(`WORD_SIZE-8){instr[7]}}, instr[7:0]};
        hlt   = (op == OP_RTYPE) && (fn == FN_HLT);
        wwd   = (op == OP_RTYPE) && (fn == FN_WWD);

        compare(T_FETCH, "i_address", m_pc, i_address);
        compare(T_HALT, "num_inst", m_count, num_inst);
        compare(T_HALT, "is_halted", hlt, is_halted);
        if (hlt) begin
            compare(T_HALT, "d_write", '0, d_write);
            compare(T_HALT, "wwd_valid", '0, wwd_valid);
        end else begin
            compare(T_MEM, "d_write", op == OP_SWD, d_write);
            compare(T_MEM, "d_read", op == OP_LWD, d_read);
            if (op inside {OP_LWD, OP_SWD}) begin
                compare(T_MEM, "d_address", regs[rs] + imm, d_address);
            end
            if (op == OP_SWD) begin
                compare(T_MEM, "d_wdata", regs[rt], d_wdata);
            end
            compare(T_ALU, "wwd_valid", wwd, wwd_valid);
            if (wwd && rs == 2'd2 && link_fresh) begin
                compare(T_LINK, "output_port", regs[2], output_port);
            end else if (wwd) begin
                compare(T_ALU, "output_port", regs[rs], output_port);
            end

            next_pc = m_pc + 1'b1;
            case (op)
                OP_BNE: if (regs[rs] != regs[rt]) next_pc = m_pc + 1'b1 + imm;
                OP_BEQ: if (regs[rs] == regs[rt]) next_pc = m_pc + 1'b1 + imm;
                OP_BGZ: if ($signed(regs[rs]) > 0) next_pc = m_pc + 1'b1 + imm;
                OP_BLZ: if ($signed(regs[rs]) < 0) next_pc = m_pc + 1'b1 + imm;
                OP_ADI: set_reg(rt, regs[rs] + imm);
                OP_ORI: set_reg(rt, regs[rs] | imm);
                OP_LHI: set_reg(rt, {instr[7:0], 8'h00});
                OP_LWD: set_reg(rt, dmem[regs[rs] + imm]);
                OP_SWD: dmem[regs[rs] + imm] = regs[rt];
                OP_JMP: next_pc = {m_pc[15:12], instr[11:0]};
                OP_JAL: begin
                    set_reg(2'd2, m_pc + 1'b1);
                    link_fresh = 1'b1;
                    next_pc    = {m_pc[15:12], instr[11:0]};
                end
                OP_RTYPE: begin
                    case (fn)
                        FN_ADD: set_reg(rd, regs[rs] + regs[rt]);
                        FN_SUB: set_reg(rd, regs[rs] - regs[rt]);
                        FN_AND: set_reg(rd, regs[rs] & regs[rt]);
                        FN_ORR: set_reg(rd, regs[rs] | regs[rt]);
                        FN_NOT: set_reg(rd, ~regs[rs]);
                        FN_TCP: set_reg(rd, `WORD_SIZE'(0) - regs[rs]);
                        FN_SHL: set_reg(rd, {regs[rs][14:0], 1'b0});
                        FN_SHR: set_reg(rd, {regs[rs][15], regs[rs][15:1]});
                        FN_JPR: next_pc = regs[rs];
                        FN_JRL: begin
                            // Target is read before the link write
                            jreg = regs[rs];
                            set_reg(2'd2, m_pc + 1'b1);
                            link_fresh = 1'b1;
                            next_pc    = jreg;
                        end
                        default: begin
                        end
                    endcase
                end
                default: begin
                end
            endcase
            m_pc    = next_pc;
            m_count = m_count + 1'b1;
        end
    endtask

    // Outputs are settled mid-cycle
    always @(negedge clk) begin
        if (!arst_n) begin
            m_pc        = `WORD_SIZE'(`PC_RESET);
            m_count     = '0;
            link_fresh  = 1'b0;
            first_cycle = 1'b1;
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] = '0;
            end
            check_reset(1'b1);
        end else begin
            if (first_cycle) begin
                check_reset(1'b0);
            end
            first_cycle = 1'b0;
            check_and_step();
        end
    end

    always @(posedge done) begin
        int total;
        total = 0;
        for (int t = 0; t < 6; t++) begin
            $display("%s: %0d checks, %0d failed", test_label(t), checks[t], fails[t]);
            total += checks[t];
        end
        $display("Summary: %0d checks, %0d failures", total, fail_count);
    end

endmodule

// ==== hdl/cpu.sv ====
`timescale 1ns/100ps
`include "tsc_params.svh"

module cpu (
    input  logic                  clk,
    input  logic                  arst_n,
    output logic [`WORD_SIZE-1:0] i_address,
    input  logic [`WORD_SIZE-1:0] i_data,
    output logic [`WORD_SIZE-1:0] d_address,
    output logic [`WORD_SIZE-1:0] d_wdata,
    input  logic [`WORD_SIZE-1:0] d_rdata,
    output logic                  d_read,
    output logic                  d_write,
    output logic [`WORD_SIZE-1:0] output_port,
    output logic                  wwd_valid,
    output logic                  is_halted,
    output logic [`WORD_SIZE-1:0] num_inst
);
    import tsc_pkg::*;

    alu_src_t  alu_src;
    alu_func_t alu_op;
    reg_dest_t reg_dest;
    pc_sel_t   pc_sel;
    logic      mem_read;
    logic      mem_write;
    logic      reg_write;
    logic      mem_to_reg;
    logic      pc_to_reg;
    logic      halt;
    logic      is_wwd;
    logic      reg_we;

    logic [1:0]            wr_addr;
    logic [`WORD_SIZE-1:0] pc;
    logic [`WORD_SIZE-1:0] pc_plus1;
    logic [`WORD_SIZE-1:0] rs_data;
    logic [`WORD_SIZE-1:0] rt_data;
    logic [`WORD_SIZE-1:0] alu_a;
    logic [`WORD_SIZE-1:0] alu_b;
    logic [`WORD_SIZE-1:0] alu_result;
    logic [`WORD_SIZE-1:0] wb_data;
    logic [`WORD_SIZE-1:0] imm_sext;
    logic [`WORD_SIZE-1:0] imm_zext;

    control u_control (
        .instruction (i_data),
        .alu_src     (alu_src),
        .alu_op      (alu_op),
        .reg_dest    (reg_dest),
        .pc_sel      (pc_sel),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .reg_write   (reg_write),
        .mem_to_reg  (mem_to_reg),
        .pc_to_reg   (pc_to_reg),
        .is_halted   (halt),
        .is_wwd      (is_wwd)
    );

    // ########################################
    // Register file and write-back
    // ########################################
    always_comb begin
        case (reg_dest)
            DEST_RT:   wr_addr = i_data[9:8];
            DEST_LINK: wr_addr = 2'd2;
            default:   wr_addr = i_data[7:6];
        endcase
    end

    assign wb_data = pc_to_reg  ? pc_plus1 :
                     mem_to_reg ? d_rdata  : alu_result;

    assign reg_we = reg_write && !halt && arst_n;

    register_file u_register_file (
        .clk     (clk),
        .arst_n  (arst_n),
        .rs_addr (i_data[11:10]),
        .rt_addr (i_data[9:8]),
        .wr_addr (wr_addr),
        .wr_en   (reg_we),
        .wr_data (wb_data),
        .rs_data (rs_data),
        .rt_data (rt_data)
    );

    // ########################################
    // ALU operands
    // ########################################
    assign imm_sext = {{(`WORD_SIZE-8){i_data[7]}}, i_data[7:0]};
    assign imm_zext = {{(`WORD_SIZE-8){1'b0}}, i_data[7:0]};

    // LHI shifts the immediate itself up by a byte
    assign alu_a = (alu_src == SRC_LHI_SHIFT) ? imm_zext : rs_data;

    always_comb begin
        case (alu_src)
            SRC_IMM:       alu_b = imm_sext;
            SRC_SHAMT:     alu_b = `WORD_SIZE'(1);
            SRC_LHI_SHIFT: alu_b = `WORD_SIZE'(8);
            default:       alu_b = rt_data;
        endcase
    end

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .func   (alu_op),
        .result (alu_result)
    );

    pc_unit u_pc_unit (
        .clk      (clk),
        .arst_n   (arst_n),
        .halt     (halt),
        .pc_sel   (pc_sel),
        .offset   (i_data[7:0]),
        .target   (i_data[11:0]),
        .opcode   (opcode_t'(i_data[15:12])),
        .rs_data  (rs_data),
        .rt_data  (rt_data),
        .jump_reg (rs_data),
        .pc       (pc),
        .pc_plus1 (pc_plus1)
    );

    assign i_address = pc;

    // Memory and output ports
    assign d_address   = alu_result;
    assign d_wdata     = rt_data;
    assign d_read      = mem_read;
    assign d_write     = mem_write && arst_n;
    assign output_port = rs_data;
    assign wwd_valid   = is_wwd && !halt && arst_n;
    assign is_halted   = halt;

    // Retired instruction count
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            num_inst <= '0;
        end else if (!halt) begin
            num_inst <= num_inst + 1'b1;
        end
    end

endmodule

// ==== datapath/pc_unit.sv ====
`timescale 1ns/100ps
`include "tsc_params.svh"

module pc_unit (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  halt,
    input  tsc_pkg::pc_sel_t      pc_sel,
    input  logic [7:0]            offset,
    input  logic [11:0]           target,
    input  tsc_pkg::opcode_t      opcode,
    input  logic [`WORD_SIZE-1:0] rs_data,
    input  logic [`WORD_SIZE-1:0] rt_data,
    input  logic [`WORD_SIZE-1:0] jump_reg,
    output logic [`WORD_SIZE-1:0] pc,
    output logic [`WORD_SIZE-1:0] pc_plus1
);
    import tsc_pkg::*;

    logic                  taken;
    logic [`WORD_SIZE-1:0] branch_pc;
    logic [`WORD_SIZE-1:0] jump_pc;
    logic [`WORD_SIZE-1:0] next_pc;

    assign pc_plus1 = pc + 1'b1;

    // ########################################
    // Branch condition
    // ########################################
    always_comb begin
        case (opcode)
            OP_BNE:  taken = (rs_data != rt_data);
            OP_BEQ:  taken = (rs_data == rt_data);
            OP_BGZ:  taken = ($signed(rs_data) > 0);
            OP_BLZ:  taken = ($signed(rs_data) < 0);
            default: taken = 1'b0;
        endcase
    end

    // Offset is relative to the following instruction
    assign branch_pc = pc_plus1 + {{(`WORD_SIZE-8){offset[7]}}, offset};
    assign jump_pc   = {pc[`WORD_SIZE-1 -: 4], target};

    always_comb begin
        case (pc_sel)
            PC_BRANCH: next_pc = taken ? branch_pc : pc_plus1;
            PC_JUMP:   next_pc = jump_pc;
            PC_REG:    next_pc = jump_reg;
            default:   next_pc = pc_plus1;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc <= `WORD_SIZE'(`PC_RESET);
        end else if (!halt) begin
            pc <= next_pc;
        end
    end

endmodule

// ==== datapath/register_file.sv ====
`timescale 1ns/100ps
`include "tsc_params.svh"

module register_file (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic [1:0]            rs_addr,
    input  logic [1:0]            rt_addr,
    input  logic [1:0]            wr_addr,
    input  logic                  wr_en,
    input  logic [`WORD_SIZE-1:0] wr_data,
    output logic [`WORD_SIZE-1:0] rs_data,
    output logic [`WORD_SIZE-1:0] rt_data
);

    logic [`WORD_SIZE-1:0] regs [`NUM_REGS];

    // Combinational read ports
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_addr] <= wr_data;
        end
    end

endmodule

// ==== datapath/alu.sv ====
`timescale 1ns/100ps
`include "tsc_params.svh"

module alu (
    input  logic [`WORD_SIZE-1:0] a,
    input  logic [`WORD_SIZE-1:0] b,
    input  tsc_pkg::alu_func_t    func,
    output logic [`WORD_SIZE-1:0] result
);
    import tsc_pkg::*;

    logic [3:0] shamt;

    // Shift distance never exceeds the word
    assign shamt = b[3:0];

    always_comb begin
        case (func)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_ORR: begin
                result = a | b;
            end
            ALU_NOT: begin
                result = ~a;
            end
            ALU_TCP: begin
                result = ~a + 1'b1;
            end
            ALU_SHL: begin
                result = a << shamt;
            end
            ALU_SHR: begin
                // Arithmetic, keeps the sign bit
                result = $signed(a) >>> shamt;
            end
            default: begin
                result = a + b;
            end
        endcase
    end

endmodule

// ==== control/control.sv ====
`timescale 1ns/100ps
`include "tsc_params.svh"

module control (
    input  logic [`WORD_SIZE-1:0] instruction,
    output tsc_pkg::alu_src_t     alu_src,
    output tsc_pkg::alu_func_t    alu_op,
    output tsc_pkg::reg_dest_t    reg_dest,
    output tsc_pkg::pc_sel_t      pc_sel,
    output logic                  mem_read,
    output logic                  mem_write,
    output logic                  reg_write,
    output logic                  mem_to_reg,
    output logic                  pc_to_reg,
    output logic                  is_halted,
    output logic                  is_wwd
);
    import tsc_pkg::*;

    opcode_t opcode;
    funct_t  funct;
    logic    rtype;
    logic    itype;
    logic    branch;
    logic    load;
    logic    store;
    logic    jal;
    logic    jrl;
    logic    jpr;
    logic    alu_funct;
    logic    shift;

    assign opcode = opcode_t'(instruction[15:12]);
    assign funct  = funct_t'(instruction[5:0]);

    // ########################################
    // Instruction classes
    // ########################################
    assign rtype  = (opcode == OP_RTYPE);
    assign branch = (opcode inside {OP_BNE, OP_BEQ, OP_BGZ, OP_BLZ});
    assign itype  = branch || (opcode inside {OP_ADI, OP_ORI, OP_LHI, OP_LWD, OP_SWD});
    assign load   = (opcode == OP_LWD);
    assign store  = (opcode == OP_SWD);
    assign jal    = (opcode == OP_JAL);
    assign jrl    = rtype && (funct == FN_JRL);
    assign jpr    = rtype && (funct == FN_JPR);
    assign shift  = rtype && (funct inside {FN_SHL, FN_SHR});

    // Functions 0..7 map straight onto the ALU
    assign alu_funct = rtype && (funct inside {FN_ADD, FN_SUB, FN_AND, FN_ORR,
                                               FN_NOT, FN_TCP, FN_SHL, FN_SHR});

    assign mem_read   = load;
    assign mem_to_reg = load;
    assign mem_write  = store;
    assign is_halted  = rtype && (funct == FN_HLT);
    assign is_wwd     = rtype && (funct == FN_WWD);
    assign pc_to_reg  = jal || jrl;

    // ADI, ORI, LHI, LWD, plus the link writes
    assign reg_write = alu_funct || jrl || jal ||
                       (opcode inside {OP_ADI, OP_ORI, OP_LHI, OP_LWD});

    always_comb begin
        if (shift) begin
            alu_src = SRC_SHAMT;
        end else if (opcode == OP_LHI) begin
            alu_src = SRC_LHI_SHIFT;
        end else if (itype) begin
            alu_src = SRC_IMM;
        end else begin
            alu_src = SRC_REG;
        end
    end

    always_comb begin
        if (jal || jrl) begin
            reg_dest = DEST_LINK;
        end else if (itype) begin
            reg_dest = DEST_RT;
        end else begin
            reg_dest = DEST_RD;
        end
    end

    always_comb begin
        if (branch) begin
            pc_sel = PC_BRANCH;
        end else if (opcode inside {OP_JMP, OP_JAL}) begin
            pc_sel = PC_JUMP;
        end else if (jpr || jrl) begin
            pc_sel = PC_REG;
        end else begin
            pc_sel = PC_SEQ;
        end
    end

    // Address arithmetic for loads and stores also uses ADD
    always_comb begin
        case (opcode)
            OP_ORI: alu_op = ALU_ORR;
            OP_LHI: alu_op = ALU_SHL;
            OP_RTYPE: begin
                case (funct)
                    FN_SUB:  alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_ORR:  alu_op = ALU_ORR;
                    FN_NOT:  alu_op = ALU_NOT;
                    FN_TCP:  alu_op = ALU_TCP;
                    FN_SHL:  alu_op = ALU_SHL;
                    FN_SHR:  alu_op = ALU_SHR;
                    default: alu_op = ALU_ADD;
                endcase
            end
            default: alu_op = ALU_ADD;
        endcase
    end

endmodule

// ==== common/tsc_pkg.sv ====
package tsc_pkg;

    // Major opcode, instruction[15:12]
    typedef enum logic [3:0] {
        OP_BNE   = 4'd0,
        OP_BEQ   = 4'd1,
        OP_BGZ   = 4'd2,
        OP_BLZ   = 4'd3,
        OP_ADI   = 4'd4,
        OP_ORI   = 4'd5,
        OP_LHI   = 4'd6,
        OP_LWD   = 4'd7,
        OP_SWD   = 4'd8,
        OP_JMP   = 4'd9,
        OP_JAL   = 4'd10,
        OP_RTYPE = 4'd15
    } opcode_t;

    // R-type function code, instruction[5:0]
    typedef enum logic [5:0] {
        FN_ADD = 6'd0,
        FN_SUB = 6'd1,
        FN_AND = 6'd2,
        FN_ORR = 6'd3,
        FN_NOT = 6'd4,
        FN_TCP = 6'd5,
        FN_SHL = 6'd6,
        FN_SHR = 6'd7,
        FN_JPR = 6'd25,
        FN_JRL = 6'd26,
        FN_WWD = 6'd28,
        FN_HLT = 6'd29
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_ORR = 3'd3,
        ALU_NOT = 3'd4,
        ALU_TCP = 3'd5,
        ALU_SHL = 3'd6,
        ALU_SHR = 3'd7
    } alu_func_t;

    // Second ALU operand
    typedef enum logic [1:0] {
        SRC_REG       = 2'b00,
        SRC_IMM       = 2'b01,
        SRC_SHAMT     = 2'b10,
        SRC_LHI_SHIFT = 2'b11
    } alu_src_t;

    typedef enum logic [1:0] {
        DEST_RD   = 2'b00,
        DEST_RT   = 2'b01,
        DEST_LINK = 2'b10
    } reg_dest_t;

    typedef enum logic [1:0] {
        PC_SEQ    = 2'b00,
        PC_BRANCH = 2'b01,
        PC_JUMP   = 2'b10,
        PC_REG    = 2'b11
    } pc_sel_t;

endpackage

// ==== common/tsc_params.svh ====
`ifndef TSC_PARAMS_SVH
`define TSC_PARAMS_SVH

// Data and address width
`define WORD_SIZE 16

// Architectural registers
`define NUM_REGS 4

// First fetch address after reset
`define PC_RESET 0

`endif
